// File: csi_host_top.f
logic/csi_host_pkg.sv
logic/sync_fifo.sv
logic/apb_master.sv
logic/csi_command_sequencer.sv
logic/pixel_capture.sv
logic/csi_host_top.sv
verification/csi_receiver_model.sv
verification/csi_host_tb.sv

// File: logic/apb_master.sv
`timescale 1ns/1ns

module apb_master
   import csi_host_pkg::*;
(
   input  logic      bus_clk,
   input  logic      arst_n,
   input  logic      op_start,
   input  reg_op_t   reg_op,
   input  apb_rsp_t  apb_rsp,
   output apb_req_t  apb_req,
   output logic      busy,
   output logic      op_done,
   output out_word_t rd_data,
   output logic      rd_push
);

   typedef enum logic [1:0] {
      A_IDLE,
      A_SETUP,
      A_ACCESS
   } apb_state_t;

   apb_state_t state;
   reg_op_t    op_q;
   logic       finish;

   assign finish = (state == A_ACCESS) && apb_rsp.pready;
   assign busy   = (state != A_IDLE);

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= A_IDLE;
         op_done <= 1'b0;
         rd_push <= 1'b0;
      end
      else
      begin
         op_done <= finish;
         rd_push <= finish && !op_q.write;
         case (state)
            A_IDLE:
               if (op_start)
                  state <= A_SETUP;
            A_SETUP:
               state <= A_ACCESS;
            A_ACCESS:
               if (apb_rsp.pready)
                  state <= A_IDLE;
            default:
               state <= A_IDLE;
         endcase
      end
   end

   // request held for the whole transfer
   always_ff @(posedge bus_clk)
   begin
      if (state == A_IDLE && op_start)
         op_q <= reg_op;
      if (finish)
         rd_data <= apb_rsp.prdata;
   end

   always_comb
   begin
      apb_req.psel    = (state != A_IDLE);
      apb_req.penable = (state == A_ACCESS);
      apb_req.pwrite  = op_q.write;
      apb_req.paddr   = op_q.addr;
      apb_req.pwdata  = op_q.wdata;
   end

endmodule

// File: logic/csi_command_sequencer.sv
`timescale 1ns/1ns

module csi_command_sequencer
   import csi_host_pkg::*;
(
   input  logic    bus_clk,
   input  logic    arst_n,
   input  logic    cmd_empty,
   input  cmd_t    cmd_byte,
   input  logic    op_busy,
   input  logic    op_done,
   input  logic    out_empty,
   input  logic    out_full,
   input  logic    frame_start,
   input  logic    frame_end,
   input  logic    out_full_seen,
   output logic    cmd_pop,
   output logic    op_start,
   output reg_op_t reg_op,
   output logic    capture_on
);

   typedef enum logic [3:0] {
      S_IDLE,
      S_DECODE,
      S_REG,
      S_WAIT_FS,
      S_STREAM,
      S_STOP_FULL,
      S_WAIT_DRAIN,
      S_RESTART,
      S_STOP_FE
   } seq_state_t;

   seq_state_t state;
   logic       issued;
   logic       cap_next;
   logic       fe_seen;
   logic       access_state;

   assign access_state = (state inside {S_REG, S_STOP_FULL, S_RESTART, S_STOP_FE});
   // reads wait for room in the output FIFO
   assign op_start   = access_state && !issued && !op_busy && (reg_op.write || !out_full);
   assign cmd_pop    = (state == S_IDLE) && !cmd_empty;
   assign capture_on = (state == S_STREAM);

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= S_IDLE;
         reg_op   <= '0;
         issued   <= 1'b0;
         cap_next <= 1'b0;
         fe_seen  <= 1'b0;
      end
      else
      begin
         if (op_start)
            issued <= 1'b1;
         else if (op_done)
            issued <= 1'b0;

         case (state)
            S_IDLE:
               if (!cmd_empty)
                  state <= S_DECODE;
            S_DECODE:
            begin
               state    <= S_REG;
               cap_next <= 1'b0;
               case (cmd_byte)
                  CMD_WRITE_ROWS:
                     reg_op <= '{write: 1'b1, addr: REG_ROWS, wdata: ROWS_VALUE};
                  CMD_WRITE_COLS:
                     reg_op <= '{write: 1'b1, addr: REG_COLS, wdata: COLS_VALUE};
                  CMD_START_CAPTURE:
                  begin
                     reg_op   <= '{write: 1'b1, addr: REG_CTRL, wdata: 32'd1};
                     cap_next <= 1'b1;
                  end
                  CMD_READ_ROWS:
                     reg_op <= '{write: 1'b0, addr: REG_ROWS, wdata: '0};
                  CMD_READ_COLS:
                     reg_op <= '{write: 1'b0, addr: REG_COLS, wdata: '0};
                  CMD_READ_CTRL:
                     reg_op <= '{write: 1'b0, addr: REG_CTRL, wdata: '0};
                  CMD_READ_CONFIG:
                     reg_op <= '{write: 1'b0, addr: REG_CONFIG, wdata: '0};
                  CMD_WRITE_CONFIG:
                     reg_op <= '{write: 1'b1, addr: REG_CONFIG, wdata: CONFIG_PARTIAL};
                  CMD_WRITE_CONFIG_ALL:
                     reg_op <= '{write: 1'b1, addr: REG_CONFIG, wdata: CONFIG_ALL};
                  // anything else is dropped
                  default:
                     state <= S_IDLE;
               endcase
            end
            S_REG:
               if (op_done)
                  state <= cap_next ? S_WAIT_FS : S_IDLE;
            S_WAIT_FS:
               if (frame_start)
                  state <= S_STREAM;
            S_STREAM:
               if (frame_end || fe_seen)
               begin
                  state   <= S_STOP_FE;
                  reg_op  <= '{write: 1'b1, addr: REG_CTRL, wdata: '0};
                  fe_seen <= 1'b0;
               end
               else if (out_full_seen)
               begin
                  state  <= S_STOP_FULL;
                  reg_op <= '{write: 1'b1, addr: REG_CTRL, wdata: '0};
               end
            S_STOP_FULL:
               if (op_done)
                  state <= S_WAIT_DRAIN;
            S_WAIT_DRAIN:
               if (out_empty)
               begin
                  state  <= S_RESTART;
                  reg_op <= '{write: 1'b1, addr: REG_CTRL, wdata: 32'd1};
               end
            S_RESTART:
               if (op_done)
                  state <= S_STREAM;
            S_STOP_FE:
               if (op_done)
                  state <= S_IDLE;
            default:
               state <= S_IDLE;
         endcase

         // frame end can land while paused for back-pressure
         if (frame_end && (state inside {S_STOP_FULL, S_WAIT_DRAIN, S_RESTART}))
            fe_seen <= 1'b1;
      end
   end

endmodule

// File: logic/csi_host_pkg.sv
package csi_host_pkg;

   // bus and counter sizes
   localparam int APB_ADDR_W = 6;
   localparam int APB_DATA_W = 32;
   localparam int PIXEL_W    = 10;
   localparam int CMD_W      = 8;
   localparam int LINE_CNT_W = 17;
   localparam int LINE_ERR_W = 4;

   // output FIFO is small so back-pressure is easy to reach
   localparam int CMD_FIFO_DEPTH = 16;
   localparam int OUT_FIFO_DEPTH = 16;

   typedef logic [CMD_W-1:0]      cmd_t;
   typedef logic [APB_DATA_W-1:0] out_word_t;

   typedef struct packed {
      logic                  write;
      logic [APB_ADDR_W-1:0] addr;
      logic [APB_DATA_W-1:0] wdata;
   } reg_op_t;

   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [APB_ADDR_W-1:0] paddr;
      logic [APB_DATA_W-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [APB_DATA_W-1:0] prdata;
      logic                  pready;
   } apb_rsp_t;

   typedef struct packed {
      logic               valid;
      logic               fs;
      logic               fe;
      logic               ls;
      logic               le;
      logic [PIXEL_W-1:0] pixel;
   } pixel_stream_t;

   // receiver register map, word addresses
   localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 6'd0;
   localparam logic [APB_ADDR_W-1:0] REG_ROWS   = 6'd1;
   localparam logic [APB_ADDR_W-1:0] REG_COLS   = 6'd2;
   localparam logic [APB_ADDR_W-1:0] REG_CONFIG = 6'd3;

   localparam out_word_t ROWS_VALUE     = 32'd1080;
   localparam out_word_t COLS_VALUE     = 32'd1920;
   localparam out_word_t CONFIG_PARTIAL = 32'd2;
   localparam out_word_t CONFIG_ALL     = 32'd3;

   // host command bytes
   localparam cmd_t CMD_WRITE_ROWS       = "a";
   localparam cmd_t CMD_WRITE_COLS       = "b";
   localparam cmd_t CMD_START_CAPTURE    = "c";
   localparam cmd_t CMD_READ_ROWS        = "d";
   localparam cmd_t CMD_READ_COLS        = "e";
   localparam cmd_t CMD_READ_CTRL        = "f";
   localparam cmd_t CMD_READ_CONFIG      = "g";
   localparam cmd_t CMD_WRITE_CONFIG     = "h";
   localparam cmd_t CMD_WRITE_CONFIG_ALL = "i";

endpackage

// File: logic/csi_host_top.sv
`timescale 1ns/1ns

module csi_host_top
   import csi_host_pkg::*;
(
   input  logic                  bus_clk,
   input  logic                  arst_n,
   input  logic                  cmd_push,
   input  cmd_t                  cmd_data,
   input  logic                  out_pop,
   input  apb_rsp_t              apb_rsp,
   input  pixel_stream_t         stream,
   output logic                  cmd_full,
   output out_word_t             out_data,
   output logic                  out_empty,
   output apb_req_t              apb_req,
   output logic [LINE_ERR_W-1:0] led
);

   cmd_t      cmd_byte;
   logic      cmd_empty;
   logic      cmd_pop;
   logic      out_full;
   logic      out_push;
   out_word_t out_push_data;
   reg_op_t   reg_op;
   logic      op_start;
   logic      op_busy;
   logic      op_done;
   out_word_t rd_data;
   logic      rd_push;
   logic      word_push;
   out_word_t word_data;
   logic      capture_on;
   logic      frame_start;
   logic      frame_end;
   logic      out_full_seen;

   // only one writer is active at a time
   assign out_push      = rd_push || word_push;
   assign out_push_data = word_push ? word_data : rd_data;

   sync_fifo #(.payload_t(cmd_t), .DEPTH(CMD_FIFO_DEPTH)) u_cmd_fifo (
      .bus_clk   (bus_clk),
      .arst_n    (arst_n),
      .push      (cmd_push),
      .push_data (cmd_data),
      .pop       (cmd_pop),
      .pop_data  (cmd_byte),
      .full      (cmd_full),
      .empty     (cmd_empty)
   );

   sync_fifo #(.payload_t(out_word_t), .DEPTH(OUT_FIFO_DEPTH)) u_out_fifo (
      .bus_clk   (bus_clk),
      .arst_n    (arst_n),
      .push      (out_push),
      .push_data (out_push_data),
      .pop       (out_pop),
      .pop_data  (out_data),
      .full      (out_full),
      .empty     (out_empty)
   );

   csi_command_sequencer u_sequencer (
      .bus_clk       (bus_clk),
      .arst_n        (arst_n),
      .cmd_empty     (cmd_empty),
      .cmd_byte      (cmd_byte),
      .op_busy       (op_busy),
      .op_done       (op_done),
      .out_empty     (out_empty),
      .out_full      (out_full),
      .frame_start   (frame_start),
      .frame_end     (frame_end),
      .out_full_seen (out_full_seen),
      .cmd_pop       (cmd_pop),
      .op_start      (op_start),
      .reg_op        (reg_op),
      .capture_on    (capture_on)
   );

   apb_master u_apb_master (
      .bus_clk  (bus_clk),
      .arst_n   (arst_n),
      .op_start (op_start),
      .reg_op   (reg_op),
      .apb_rsp  (apb_rsp),
      .apb_req  (apb_req),
      .busy     (op_busy),
      .op_done  (op_done),
      .rd_data  (rd_data),
      .rd_push  (rd_push)
   );

   pixel_capture u_pixel_capture (
      .bus_clk       (bus_clk),
      .arst_n        (arst_n),
      .stream        (stream),
      .capture_on    (capture_on),
      .out_full      (out_full),
      .word_push     (word_push),
      .word_data     (word_data),
      .frame_start   (frame_start),
      .frame_end     (frame_end),
      .out_full_seen (out_full_seen),
      .line_err      (led)
   );

endmodule

// File: logic/pixel_capture.sv
`timescale 1ns/1ns

module pixel_capture
   import csi_host_pkg::*;
(
   input  logic                  bus_clk,
   input  logic                  arst_n,
   input  pixel_stream_t         stream,
   input  logic                  capture_on,
   input  logic                  out_full,
   output logic                  word_push,
   output out_word_t             word_data,
   output logic                  frame_start,
   output logic                  frame_end,
   output logic                  out_full_seen,
   output logic [LINE_ERR_W-1:0] line_err
);

   logic               valid_q;
   logic               ls_q;
   logic               le_q;
   logic [PIXEL_W-1:0] pixel_q;
   logic [LINE_CNT_W-1:0] ls_cnt;
   logic [LINE_CNT_W-1:0] le_cnt;

   // stage register, push checked against full at write time
   assign word_push     = capture_on && valid_q && !out_full;
   assign word_data     = {{(APB_DATA_W-PIXEL_W){1'b0}}, pixel_q};
   assign out_full_seen = capture_on && out_full;

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         valid_q     <= 1'b0;
         frame_start <= 1'b0;
         frame_end   <= 1'b0;
         ls_q        <= 1'b0;
         le_q        <= 1'b0;
         ls_cnt      <= '0;
         le_cnt      <= '0;
         line_err    <= '0;
      end
      else
      begin
         valid_q     <= stream.valid;
         frame_start <= stream.fs;
         frame_end   <= stream.fe;
         ls_q        <= stream.ls;
         le_q        <= stream.le;
         if (capture_on)
         begin
            // line start while previous line still open
            if (ls_q)
            begin
               if (ls_cnt != le_cnt)
                  line_err <= line_err + 1'b1;
               ls_cnt <= ls_cnt + 1'b1;
            end
            if (le_q)
               le_cnt <= le_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge bus_clk)
   begin
      pixel_q <= stream.pixel;
   end

endmodule

// File: logic/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo
   import csi_host_pkg::*;
#(
   parameter type payload_t = out_word_t,
   parameter int  DEPTH     = OUT_FIFO_DEPTH
)
(
   input  logic     bus_clk,
   input  logic     arst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t pop_data,
   output logic     full,
   output logic     empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W:0]   count;
   logic             do_push;
   logic             do_pop;

   assign full    = (count == (PTR_W+1)'(DEPTH));
   assign empty   = (count == '0);
   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   // pointers and fill level
   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   // storage, read word shows up the cycle after the pop
   always_ff @(posedge bus_clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
      if (do_pop)
         pop_data <= mem[rd_ptr];
   end

endmodule

// File: verification/csi_host_tb.sv
`timescale 1ns/1ns

module csi_host_tb
   import csi_host_pkg::*;
();

   localparam int CLK_PERIOD   = 100;
   localparam int DRIVE_DELAY  = 10;
   localparam int RESET_CYCLES = 5;
   localparam int FRAME_PIXELS = 40;
   // three frames of roughly 550 cycles plus register traffic, with wide margin
   localparam int MAX_CYCLES   = 20000;

   logic                  bus_clk;
   logic                  arst_n;
   logic                  cmd_push;
   cmd_t                  cmd_data;
   logic                  cmd_full;
   logic                  out_pop;
   out_word_t             out_data;
   logic                  out_empty;
   apb_req_t              apb_req;
   apb_rsp_t              apb_rsp;
   pixel_stream_t         stream;
   logic [LINE_ERR_W-1:0] led;
   logic                  line_fault;
   logic                  model_enable;
   int                    emitted;
   int                    frames;
   int                    mismatches;

   logic      drain_en;
   out_word_t got_q [$];
   int        cycles = 0;
   int        transfers = 0;
   int        rises = 0;
   int        falls = 0;
   int        t0;
   apb_req_t  prev_req = '0;
   apb_rsp_t  prev_rsp = '0;
   logic      prev_enable = 1'b0;

   csi_host_top dut (
      .bus_clk   (bus_clk),
      .arst_n    (arst_n),
      .cmd_push  (cmd_push),
      .cmd_data  (cmd_data),
      .out_pop   (out_pop),
      .apb_rsp   (apb_rsp),
      .stream    (stream),
      .cmd_full  (cmd_full),
      .out_data  (out_data),
      .out_empty (out_empty),
      .apb_req   (apb_req),
      .led       (led)
   );

   csi_receiver_model u_receiver (
      .bus_clk    (bus_clk),
      .arst_n     (arst_n),
      .apb_req    (apb_req),
      .line_fault (line_fault),
      .apb_rsp    (apb_rsp),
      .stream     (stream),
      .enable     (model_enable),
      .emitted    (emitted),
      .frames     (frames),
      .mismatches (mismatches)
   );

   initial
   begin
      bus_clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
   end

   task automatic report_mismatch(input string msg);
      begin
         $display("MISMATCH at %0t ns: %s", $time, msg);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic tick;
      begin
         @(posedge bus_clk);
         #DRIVE_DELAY;
      end
   endtask

   task automatic send_cmd(input cmd_t c);
      begin
         while (cmd_full)
            tick();
         cmd_push = 1'b1;
         cmd_data = c;
         tick();
         cmd_push = 1'b0;
      end
   endtask

   task automatic wait_words(input int n);
      begin
         while (got_q.size() < n)
            @(negedge bus_clk);
         tick();
      end
   endtask

   task automatic check_word(input int idx, input out_word_t exp);
      begin
         assert (got_q[idx] == exp)
         else report_mismatch($sformatf("word %0d is %0d, expected %0d", idx, got_q[idx], exp));
      end
   endtask

   // one full frame, optionally with the host holding off until the FIFO fills
   task automatic capture_frame(input logic stall);
      int n0;
      int f0;
      int r0;
      int fl0;
      int i;
      begin
         n0  = got_q.size();
         f0  = frames;
         r0  = rises;
         fl0 = falls;
         drain_en = !stall;
         send_cmd(CMD_START_CAPTURE);
         if (stall)
         begin
            while (falls == fl0)
               @(negedge bus_clk);
            tick();
            // paused sequencer pops nothing, so these fill the command FIFO
            for (i = 0; i < CMD_FIFO_DEPTH; i++)
               send_cmd(8'h7a);
            repeat (4)
               tick();
            assert (cmd_full && !out_empty)
            else report_mismatch("command FIFO not held while capture was paused");
            drain_en = 1'b1;
         end
         while (frames < f0 + 1 || got_q.size() < n0 + FRAME_PIXELS || model_enable)
            @(negedge bus_clk);
         tick();
         assert (got_q.size() == n0 + FRAME_PIXELS)
         else report_mismatch($sformatf("%0d words read for one frame", got_q.size() - n0));
         for (i = 0; i < FRAME_PIXELS; i++)
            check_word(n0 + i, out_word_t'(i + 1));
         assert (rises == r0 + 1 + int'(stall) && falls == fl0 + 1 + int'(stall))
         else report_mismatch($sformatf("enable rose %0d and fell %0d times",
                                        rises - r0, falls - fl0));
      end
   endtask

   // host side of the output FIFO, word shows up the cycle after the pop
   initial
   begin
      out_pop = 1'b0;
      forever
      begin
         tick();
         if (out_pop)
            got_q.push_back(out_data);
         out_pop = drain_en && !out_empty;
      end
   end

   // APB protocol and receiver enable monitor
   always @(negedge bus_clk)
   begin
      if (arst_n)
      begin
         assert (!apb_req.penable || (apb_req.psel && prev_req.psel))
         else report_mismatch("penable without a preceding setup phase");
         if (prev_req.psel && !prev_req.penable)
            assert (apb_req.psel && apb_req.penable)
            else report_mismatch("setup phase not followed by access phase");
         if (prev_req.penable && !prev_rsp.pready)
            assert (apb_req.penable && apb_req.paddr == prev_req.paddr &&
                    apb_req.pwrite == prev_req.pwrite && apb_req.pwdata == prev_req.pwdata)
            else report_mismatch("access phase changed before pready");
         if (prev_req.penable && prev_rsp.pready)
            assert (!apb_req.penable)
            else report_mismatch("access phase held after pready");
         if (apb_req.psel && apb_req.penable && apb_rsp.pready)
            transfers++;
         // mid-frame pause only at a full FIFO, resume only once drained
         if (model_enable && !prev_enable)
         begin
            rises++;
            if (emitted > 0 && emitted < FRAME_PIXELS)
               assert (out_empty)
               else report_mismatch("receiver re-enabled before the FIFO was drained");
         end
         if (!model_enable && prev_enable)
         begin
            falls++;
            if (emitted > 0 && emitted < FRAME_PIXELS)
               assert (emitted == OUT_FIFO_DEPTH)
               else report_mismatch($sformatf("receiver paused after %0d pixels", emitted));
         end
      end
      prev_req    = apb_req;
      prev_rsp    = apb_rsp;
      prev_enable = model_enable;
   end

   initial
   begin
      while (cycles < MAX_CYCLES)
      begin
         @(posedge bus_clk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1);
   end

   initial
   begin
      arst_n     = 1'b0;
      cmd_push   = 1'b0;
      cmd_data   = '0;
      drain_en   = 1'b0;
      line_fault = 1'b0;
      repeat (RESET_CYCLES)
         tick();
      arst_n = 1'b1;
      @(negedge bus_clk);
      assert (!apb_req.psel && !apb_req.penable)
      else report_mismatch("APB not idle after reset");
      assert (out_empty)
      else report_mismatch("output FIFO not empty after reset");
      assert (led == '0)
      else report_mismatch($sformatf("led is %0d after reset", led));
      tick();

      // register writes, each one read back
      drain_en = 1'b1;
      t0 = transfers;
      send_cmd(CMD_WRITE_ROWS);
      send_cmd(CMD_READ_ROWS);
      send_cmd(CMD_WRITE_COLS);
      send_cmd(CMD_READ_COLS);
      send_cmd(CMD_WRITE_CONFIG);
      send_cmd(CMD_READ_CONFIG);
      send_cmd(CMD_WRITE_CONFIG_ALL);
      send_cmd(CMD_READ_CONFIG);
      wait_words(4);
      check_word(0, ROWS_VALUE);
      check_word(1, COLS_VALUE);
      check_word(2, CONFIG_PARTIAL);
      check_word(3, CONFIG_ALL);
      assert (transfers == t0 + 8)
      else report_mismatch($sformatf("%0d APB transfers for 8 commands", transfers - t0));

      // unknown byte must be dropped without a bus cycle
      send_cmd(8'h7a);
      send_cmd(CMD_READ_ROWS);
      wait_words(5);
      check_word(4, ROWS_VALUE);
      assert (transfers == t0 + 9 && got_q.size() == 5)
      else report_mismatch("unknown command caused bus traffic or output");

      // capture with prompt draining, then control reads back disabled
      capture_frame(1'b0);
      send_cmd(CMD_READ_CTRL);
      wait_words(5 + FRAME_PIXELS + 1);
      check_word(5 + FRAME_PIXELS, '0);

      capture_frame(1'b1);

      line_fault = 1'b1;
      capture_frame(1'b0);
      line_fault = 1'b0;
      assert (mismatches == 2)
      else report_mismatch($sformatf("model counted %0d line mismatches", mismatches));
      assert (led == LINE_ERR_W'(mismatches))
      else report_mismatch($sformatf("led is %0d, expected %0d", led, mismatches));

      $display("Simulation passed");
      $finish;
   end

endmodule

// File: verification/csi_receiver_model.sv
`timescale 1ns/1ns

module csi_receiver_model
   import csi_host_pkg::*;
(
   input  logic          bus_clk,
   input  logic          arst_n,
   input  apb_req_t      apb_req,
   input  logic          line_fault,
   output apb_rsp_t      apb_rsp,
   output pixel_stream_t stream,
   output logic          enable,
   output int            emitted,
   output int            frames,
   output int            mismatches
);

   localparam int FRAME_PIXELS = 40;
   localparam int LINE_PIXELS  = 8;
   // pixel spacing leaves room for the enable write after a full FIFO
   localparam int PIXEL_GAP    = 12;
   localparam int RESUME_HOLD  = 3;
   localparam int P_READY      = 0;
   localparam int P_FRAME      = 1;
   localparam int P_DONE       = 2;

   out_word_t             regs [4];
   logic                  wr_pend;
   logic [APB_ADDR_W-1:0] wr_addr;
   out_word_t             wr_data;
   logic                  in_reset;
   int                    seed = 32'h4cf4;
   int                    waits;
   int                    gap;
   int                    hold;
   int                    phase;
   int                    ls_cnt;
   int                    le_cnt;

   assign enable = regs[REG_CTRL][0];

   task automatic clear_state;
      int i;
      begin
         for (i = 0; i < 4; i++)
            regs[i] = '0;
         wr_pend    = 1'b0;
         wr_addr    = '0;
         wr_data    = '0;
         apb_rsp    = '0;
         stream     = '0;
         waits      = 0;
         gap        = 0;
         hold       = RESUME_HOLD;
         phase      = P_READY;
         ls_cnt     = 0;
         le_cnt     = 0;
         emitted    = 0;
         frames     = 0;
         mismatches = 0;
      end
   endtask

   task automatic apb_step;
      begin
         apb_rsp.pready = 1'b0;
         // write lands on the edge that ended the transfer
         if (wr_pend)
         begin
            regs[wr_addr[1:0]] = wr_data;
            wr_pend = 1'b0;
         end
         if (apb_req.psel && !apb_req.penable)
            waits = $random(seed) & 3;
         else if (apb_req.psel && apb_req.penable)
         begin
            if (waits == 0)
            begin
               apb_rsp.pready = 1'b1;
               apb_rsp.prdata = regs[apb_req.paddr[1:0]];
               if (apb_req.pwrite)
               begin
                  wr_pend = 1'b1;
                  wr_addr = apb_req.paddr;
                  wr_data = apb_req.pwdata;
               end
            end
            else
               waits = waits - 1;
         end
      end
   endtask

   task automatic emit_pixel;
      int   pos;
      logic fault_line;
      begin
         pos        = emitted % LINE_PIXELS;
         fault_line = line_fault && (emitted / LINE_PIXELS == 0 || emitted / LINE_PIXELS == 2);
         stream.valid = 1'b1;
         stream.pixel = PIXEL_W'(emitted + 1);
         // faulty lines get a second line start, balanced by an early line end
         stream.ls = (pos == 0) || (fault_line && pos == 3);
         stream.le = (pos == LINE_PIXELS - 1) || (fault_line && pos == 4);
         if (stream.ls)
         begin
            if (ls_cnt != le_cnt)
               mismatches = mismatches + 1;
            ls_cnt = ls_cnt + 1;
         end
         if (stream.le)
            le_cnt = le_cnt + 1;
         emitted = emitted + 1;
      end
   endtask

   task automatic pixel_step;
      begin
         stream = '0;
         if (!enable)
            hold = RESUME_HOLD;
         else if (hold > 0)
            hold = hold - 1;
         if (gap > 0)
            gap = gap - 1;
         case (phase)
            P_READY:
               if (enable && hold == 0)
               begin
                  stream.fs = 1'b1;
                  emitted   = 0;
                  gap       = PIXEL_GAP;
                  phase     = P_FRAME;
               end
            P_FRAME:
               if (enable && hold == 0 && gap == 0)
               begin
                  if (emitted == FRAME_PIXELS)
                  begin
                     stream.fe = 1'b1;
                     frames    = frames + 1;
                     phase     = P_DONE;
                  end
                  else
                     emit_pixel();
                  gap = PIXEL_GAP;
               end
            default:
               if (!enable)
                  phase = P_READY;
         endcase
      end
   endtask

   initial
   begin
      clear_state();
      forever
      begin
         @(posedge bus_clk);
         in_reset = !arst_n;
         #10;
         if (in_reset)
            clear_state();
         else
         begin
            apb_step();
            pixel_step();
         end
      end
   end

endmodule
